// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= tb_sha_core
FILELIST  ?= sha_core.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: sha_core.f
+incdir+.
sha_pkg.sv
sha_ctrl.sv
sha_round.sv
sha_schedule.sv
sha_digest.sv
sha_core.sv
tb_sha_core.sv

// File: sha_core.sv
`timescale 1ns/1ps

module sha_core (
  input  logic                 clk,
  input  logic                 rst_i,
  input  logic                 block_valid_i,
  input  logic                 first_i,
  input  sha_pkg::msg_block_t  block_i,
  output logic                 busy_o,
  output logic                 done_o,
  output sha_pkg::hash_state_t digest_o
);

  import sha_pkg::*;

  // control strobes
  logic                   start;
  logic                   step;
  logic                   finish;
  logic [ROUND_IDX_W-1:0] round_idx;

  // datapath words
  logic [31:0]            w_word;
  hash_state_t            chain;
  hash_state_t            round_state;

  sha_ctrl u_ctrl (
    .clk           (clk),
    .rst_i         (rst_i),
    .block_valid_i (block_valid_i),
    .busy_o        (busy_o),
    .done_o        (done_o),
    .start_o       (start),
    .step_o        (step),
    .finish_o      (finish),
    .round_idx_o   (round_idx)
  );

  // W source, one word per round
  sha_schedule u_schedule (
    .clk     (clk),
    .start_i (start),
    .step_i  (step),
    .block_i (block_i),
    .w_o     (w_word)
  );

  // two-rank round loop
  sha_round u_round (
    .clk         (clk),
    .start_i     (start),
    .chain_i     (chain),
    .round_idx_i (round_idx),
    .w_i         (w_word),
    .state_o     (round_state)
  );

  // chaining value and final add
  sha_digest u_digest (
    .clk           (clk),
    .rst_i         (rst_i),
    .start_i       (start),
    .first_i       (first_i),
    .finish_i      (finish),
    .round_state_i (round_state),
    .chain_o       (chain),
    .digest_o      (digest_o)
  );

endmodule

// File: sha_ctrl.sv
`timescale 1ns/1ps

module sha_ctrl (
  input  logic                            clk,
  input  logic                            rst_i,
  input  logic                            block_valid_i,
  output logic                            busy_o,
  output logic                            done_o,
  output logic                            start_o,
  output logic                            step_o,
  output logic                            finish_o,
  output logic [sha_pkg::ROUND_IDX_W-1:0] round_idx_o
);

  import sha_pkg::*;

  ctrl_state_t            state_q;
  // 0 issue cycle, 1 rank move cycle
  logic                   phase_q;
  logic [ROUND_IDX_W-1:0] idx_q;
  logic                   done_q;
  logic                   last_step;

  // accept only when idle and not showing done
  assign start_o = block_valid_i && (state_q == CTRL_IDLE) && !done_q;

  // advance schedule and index in the second cycle of a round
  assign step_o = (state_q == CTRL_ROUND) && phase_q;

  // round 63 leaving rank 1
  assign last_step = step_o && (idx_q == ROUND_IDX_W'(SHA_ROUNDS - 1));

  // one cycle, result of round 63 sits in rank 2
  assign finish_o = (state_q == CTRL_FINISH);

  // busy through the done cycle
  assign busy_o = (state_q != CTRL_IDLE) || done_q;

  assign done_o      = done_q;
  assign round_idx_o = idx_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= CTRL_IDLE;
      phase_q <= 1'b0;
      idx_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      // done only lasts a cycle
      done_q <= 1'b0;
      case (state_q)
        CTRL_IDLE: begin
          if (start_o) begin
            state_q <= CTRL_ROUND;
            phase_q <= 1'b0;
            idx_q   <= '0;
          end
        end
        CTRL_ROUND: begin
          phase_q <= ~phase_q;
          // index wraps back to 0 after the last round
          if (step_o) begin
            idx_q <= idx_q + 1'b1;
          end
          if (last_step) begin
            state_q <= CTRL_FINISH;
          end
        end
        CTRL_FINISH: begin
          // digest add happens on this edge
          state_q <= CTRL_IDLE;
          done_q  <= 1'b1;
        end
        default: begin
          state_q <= CTRL_IDLE;
        end
      endcase
    end
  end

endmodule

// File: sha_digest.sv
`timescale 1ns/1ps

module sha_digest (
  input  logic                 clk,
  input  logic                 rst_i,
  input  logic                 start_i,
  input  logic                 first_i,
  input  logic                 finish_i,
  input  sha_pkg::hash_state_t round_state_i,
  output sha_pkg::hash_state_t chain_o,
  output sha_pkg::hash_state_t digest_o
);

  import sha_pkg::*;

  // chaining value, doubles as the visible digest
  hash_state_t chain_q;
  hash_state_t sum;

  // word-wise add, carries drop at 32 bits
  always_comb begin
    sum.a = chain_q.a + round_state_i.a;
    sum.b = chain_q.b + round_state_i.b;
    sum.c = chain_q.c + round_state_i.c;
    sum.d = chain_q.d + round_state_i.d;
    sum.e = chain_q.e + round_state_i.e;
    sum.f = chain_q.f + round_state_i.f;
    sum.g = chain_q.g + round_state_i.g;
    sum.h = chain_q.h + round_state_i.h;
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      chain_q <= SHA_IV;
    end else if (start_i && first_i) begin
      // new message restarts from the iv
      chain_q <= SHA_IV;
    end else if (finish_i) begin
      chain_q <= sum;
    end
    // continuation just keeps the last digest
  end

  // rounds read it frozen, caller sees it after the add
  assign chain_o  = chain_q;
  assign digest_o = chain_q;

endmodule

// File: sha_pkg.sv
package sha_pkg;

  // working state and digest, a in the top word
  typedef struct packed {
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [31:0] e;
    logic [31:0] f;
    logic [31:0] g;
    logic [31:0] h;
  } hash_state_t;

  // word 0 is the first big-endian word of the block
  typedef logic [0:15][31:0] msg_block_t;

  localparam int SHA_ROUNDS  = 64;
  localparam int ROUND_IDX_W = 6;

  // round constants, FIPS 180-4
  localparam logic [31:0] SHA_K [0:SHA_ROUNDS-1] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  // standard initial hash value, a first
  localparam hash_state_t SHA_IV = '{
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_ROUND,
    CTRL_FINISH
  } ctrl_state_t;

  // rotate right by n
  function automatic logic [31:0] rotr(input logic [31:0] x, input int n);
    return (x >> n) | (x << (32 - n));
  endfunction

  function automatic logic [31:0] big_sigma0(input logic [31:0] x);
    return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
  endfunction

  function automatic logic [31:0] big_sigma1(input logic [31:0] x);
    return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
  endfunction

  // schedule sigmas use a plain shift in the last term
  function automatic logic [31:0] small_sigma0(input logic [31:0] x);
    return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
  endfunction

  function automatic logic [31:0] small_sigma1(input logic [31:0] x);
    return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
  endfunction

  function automatic logic [31:0] ch_fn(input logic [31:0] x, input logic [31:0] y,
                                        input logic [31:0] z);
    return (x & y) ^ (~x & z);
  endfunction

  function automatic logic [31:0] maj_fn(input logic [31:0] x, input logic [31:0] y,
                                         input logic [31:0] z);
    return (x & y) ^ (x & z) ^ (y & z);
  endfunction

endpackage

// File: sha_round.sv
`timescale 1ns/1ps

module sha_round (
  input  logic                          clk,
  input  logic                          start_i,
  input  sha_pkg::hash_state_t          chain_i,
  input  logic [sha_pkg::ROUND_IDX_W-1:0] round_idx_i,
  input  logic [31:0]                   w_i,
  output sha_pkg::hash_state_t          state_o
);

  import sha_pkg::*;

  // start seen last cycle, pick up the chaining value
  logic        start_q;
  hash_state_t cur;
  hash_state_t nxt;
  hash_state_t rank1_q;
  hash_state_t rank2_q;
  logic [31:0] k_word;
  logic [31:0] t1;
  logic [31:0] t2;

  always_ff @(posedge clk) begin
    start_q <= start_i;
  end

  // round input, chain on first issue, else loop back from rank 2
  assign cur = start_q ? chain_i : rank2_q;

  // constant for this round
  assign k_word = SHA_K[round_idx_i];

  // t1 from the e side
  assign t1 = cur.h + big_sigma1(cur.e) + ch_fn(cur.e, cur.f, cur.g) + k_word + w_i;
  // t2 from the a side
  assign t2 = big_sigma0(cur.a) + maj_fn(cur.a, cur.b, cur.c);

  // rotate the working words down by one
  always_comb begin
    nxt.a = t1 + t2;
    nxt.b = cur.a;
    nxt.c = cur.b;
    nxt.d = cur.c;
    nxt.e = cur.d + t1;
    nxt.f = cur.e;
    nxt.g = cur.f;
    nxt.h = cur.g;
  end

  // two ranks in the loop, one round per two cycles
  // ranks run free, the off-phase slot just carries a dead copy
  always_ff @(posedge clk) begin
    rank1_q <= nxt;
    rank2_q <= rank1_q;
  end

  assign state_o = rank2_q;

endmodule

// File: sha_schedule.sv
`timescale 1ns/1ps

module sha_schedule (
  input  logic                clk,
  input  logic                start_i,
  input  logic                step_i,
  input  sha_pkg::msg_block_t block_i,
  output logic [31:0]         w_o
);

  import sha_pkg::*;

  // sliding window of W[t-16] .. W[t-1], index 0 oldest
  logic [31:0] win_q [16];
  logic [31:0] w_new;

  // W[t] = s1(W[t-2]) + W[t-7] + s0(W[t-15]) + W[t-16]
  assign w_new = small_sigma1(win_q[14]) + win_q[9] + small_sigma0(win_q[1]) + win_q[0];

  always_ff @(posedge clk) begin
    if (start_i) begin
      // block words straight in, first word at the head
      for (int i = 0; i < 16; i++) begin
        win_q[i] <= block_i[i];
      end
    end else if (step_i) begin
      // drop oldest, append the next expanded word
      for (int i = 0; i < 15; i++) begin
        win_q[i] <= win_q[i+1];
      end
      win_q[15] <= w_new;
    end
  end

  // current round word
  assign w_o = win_q[0];

endmodule

// File: tb_sha_model.svh
`ifndef TB_SHA_MODEL_SVH
`define TB_SHA_MODEL_SVH

// chaining value the model carries from block to block
hash_state_t model_chain;

// one block through the 64 rounds, written straight from the standard
function automatic hash_state_t compress_block(input hash_state_t h_in,
                                               input msg_block_t blk);
  logic [31:0] w [0:63];
  hash_state_t s;
  hash_state_t r;
  logic [31:0] t1;
  logic [31:0] t2;
  // expand the full schedule up front
  for (int t = 0; t < 16; t++) begin
    w[t] = blk[t];
  end
  for (int t = 16; t < 64; t++) begin
    w[t] = small_sigma1(w[t-2]) + w[t-7] + small_sigma0(w[t-15]) + w[t-16];
  end
  s = h_in;
  for (int t = 0; t < 64; t++) begin
    t1 = s.h + big_sigma1(s.e) + ch_fn(s.e, s.f, s.g) + SHA_K[t] + w[t];
    t2 = big_sigma0(s.a) + maj_fn(s.a, s.b, s.c);
    s.h = s.g;
    s.g = s.f;
    s.f = s.e;
    s.e = s.d + t1;
    s.d = s.c;
    s.c = s.b;
    s.b = s.a;
    s.a = t1 + t2;
  end
  // feed forward into the input value
  r.a = h_in.a + s.a;
  r.b = h_in.b + s.b;
  r.c = h_in.c + s.c;
  r.d = h_in.d + s.d;
  r.e = h_in.e + s.e;
  r.f = h_in.f + s.f;
  r.g = h_in.g + s.g;
  r.h = h_in.h + s.h;
  return r;
endfunction

// new message restarts from the iv, otherwise chain on
function automatic hash_state_t model_block(input logic first, input msg_block_t blk);
  if (first) begin
    model_chain = SHA_IV;
  end
  model_chain = compress_block(model_chain, blk);
  return model_chain;
endfunction

`endif

// File: tb_sha_core.sv
`timescale 1ns/1ps

module tb_sha_core;

  import sha_pkg::*;

  // strobe cycle to done cycle
  localparam int DONE_LATENCY    = 130;
  // 1 known, 40 random, 8 chained, 4 noisy, 2 around the reset
  localparam int NUM_BLOCKS      = 55;
  localparam int WATCHDOG_CYCLES = NUM_BLOCKS * 140 + 100;

  // published digest of "abc"
  localparam hash_state_t ABC_DIGEST = '{
    32'hba7816bf, 32'h8f01cfea, 32'h414140de, 32'h5dae2223,
    32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad
  };

  logic        clk;
  logic        rst_i;
  logic        block_valid_i;
  logic        first_i;
  msg_block_t  block_i;
  logic        busy_o;
  logic        done_o;
  hash_state_t digest_o;
  integer      seed;

  `include "tb_sha_model.svh"

  sha_core DUT (
    .clk           (clk),
    .rst_i         (rst_i),
    .block_valid_i (block_valid_i),
    .first_i       (first_i),
    .block_i       (block_i),
    .busy_o        (busy_o),
    .done_o        (done_o),
    .digest_o      (digest_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_digest(input string name, input hash_state_t got,
                              input hash_state_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      abort_run("digest compare failed");
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h expected %h", name, got, exp);
      abort_run("control output compare failed");
    end
  endtask

  function automatic msg_block_t random_block();
    msg_block_t blk;
    for (int i = 0; i < 16; i++) begin
      blk[i] = $random(seed);
    end
    return blk;
  endfunction

  // core must sit idle for one quiet cycle
  task automatic expect_idle();
    @(negedge clk);
    check_bit("busy_o", busy_o, 1'b0);
    check_bit("done_o", done_o, 1'b0);
  endtask

  task automatic idle_gap();
    logic [31:0] rnd;
    rnd = $random(seed);
    repeat (rnd[1:0]) expect_idle();
  endtask

  // strobe one block and walk the busy window cycle by cycle
  task automatic run_block(input msg_block_t blk, input logic first, input logic noisy);
    hash_state_t expected;
    logic [31:0] rnd;
    expected = model_block(first, blk);
    @(posedge clk);
    block_valid_i <= 1'b1;
    first_i       <= first;
    block_i       <= blk;
    // edge 0 samples the strobe
    @(posedge clk);
    block_valid_i <= 1'b0;
    for (int cyc = 1; cyc <= DONE_LATENCY; cyc++) begin
      @(negedge clk);
      check_bit("busy_o", busy_o, 1'b1);
      check_bit("done_o", done_o, cyc == DONE_LATENCY);
      if (cyc == DONE_LATENCY) begin
        check_digest("digest_o", digest_o, expected);
      end
      @(posedge clk);
      rnd = $random(seed);
      // stray strobe with other data up to the done cycle
      if (noisy && cyc < DONE_LATENCY && rnd[1:0] == 2'b00) begin
        block_valid_i <= 1'b1;
        first_i       <= rnd[2];
        block_i       <= random_block();
      end else begin
        block_valid_i <= 1'b0;
      end
    end
    // done gone after one cycle
    expect_idle();
  endtask

  initial begin
    msg_block_t  blk;
    hash_state_t model_abc;
    seed          = 32'h5a16;
    rst_i         = 1'b1;
    block_valid_i = 1'b0;
    first_i       = 1'b0;
    block_i       = '0;
    repeat (5) @(posedge clk);
    rst_i <= 1'b0;
    expect_idle();
    check_digest("digest_o", digest_o, SHA_IV);

    // padded "abc" through the model first and then the core
    blk     = '0;
    blk[0]  = 32'h61626380;
    blk[15] = 32'h00000018;
    model_abc = compress_block(SHA_IV, blk);
    check_digest("model digest", model_abc, ABC_DIGEST);
    run_block(blk, 1'b1, 1'b0);
    check_digest("digest_o", digest_o, ABC_DIGEST);

    // independent single blocks
    repeat (40) begin
      run_block(random_block(), 1'b1, 1'b0);
      idle_gap();
    end

    // multi block message that restarts and then continues
    run_block(random_block(), 1'b1, 1'b0);
    repeat (5) begin
      run_block(random_block(), 1'b0, 1'b0);
      idle_gap();
    end
    run_block(random_block(), 1'b1, 1'b0);
    run_block(random_block(), 1'b0, 1'b0);

    // strobes while busy on a chained message so a stray first_i would show
    repeat (4) begin
      run_block(random_block(), 1'b0, 1'b1);
    end

    // reset in the middle of the rounds
    // continuation block so only the reset brings back the iv
    @(posedge clk);
    block_valid_i <= 1'b1;
    first_i       <= 1'b0;
    block_i       <= random_block();
    @(posedge clk);
    block_valid_i <= 1'b0;
    repeat (40) @(posedge clk);
    @(negedge clk);
    check_bit("busy_o", busy_o, 1'b1);
    @(posedge clk);
    rst_i <= 1'b1;
    @(posedge clk);
    rst_i <= 1'b0;
    expect_idle();
    check_digest("digest_o", digest_o, SHA_IV);
    run_block(random_block(), 1'b1, 1'b0);

    $display("test passed");
    $finish;
  end

  // bound on the whole run
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run("timed out waiting for the core to finish its blocks");
  end

endmodule
